//--- design/cnn_dt_pkg.sv
`default_nettype none

package cnn_dt_pkg;

    ////////////////////
    // Pixel and tile geometry
    ////////////////////

    // Bits per pixel or weight
    localparam int DATA_WIDTH = 8;

    // Pixel tile carried in one feature-map word
    localparam int PARA_X = 3;
    localparam int PARA_Y = 4;

    // Kernels loaded side by side
    localparam int PARA_KERNEL = 2;

    // Kernel side, 9 weights per kernel word
    localparam int KERNEL_SIZE_MAX = 3;

    ////////////////////
    // Feature-map transfer
    ////////////////////

    // Words copied on each init
    localparam int FM_DEPTH = 16;
    // Source ROM address width
    localparam int FM_ADDR_WIDTH = $clog2(FM_DEPTH);
    // Buffer write port is wider than the ROM
    localparam int WRITE_ADDR_WIDTH = 5;
    localparam int FM_SALT = 0;

    ////////////////////
    // Weight transfer
    ////////////////////

    // Words in each kernel store
    localparam int WEIGHT_DEPTH = 16;
    localparam int WEIGHT_WRITE_ADDR_WIDTH = 4;
    // Words per kernel per update
    localparam int WEIGHT_BURST = 4;
    localparam int BURST_CNT_WIDTH = $clog2(WEIGHT_BURST);
    // Kernel k uses salt step times (k+1)
    localparam int WEIGHT_SALT_STEP = 17;

    ////////////////////
    // Word types
    ////////////////////

    localparam int FM_WORD_WIDTH = PARA_X * PARA_Y * DATA_WIDTH;
    localparam int WEIGHT_WORD_WIDTH = KERNEL_SIZE_MAX * KERNEL_SIZE_MAX * DATA_WIDTH;

    // Packed per-kernel buses, kernel 0 lowest
    localparam int WEIGHT_BUS_WIDTH = PARA_KERNEL * WEIGHT_WORD_WIDTH;
    localparam int WEIGHT_ADDR_BUS_WIDTH = PARA_KERNEL * WEIGHT_WRITE_ADDR_WIDTH;

    typedef logic [FM_WORD_WIDTH-1:0] fm_word_t;
    typedef logic [WEIGHT_WORD_WIDTH-1:0] weight_word_t;

endpackage

`default_nettype wire

//--- design/source_rom.sv
`default_nettype none

module source_rom import cnn_dt_pkg::*; #(
    parameter type word_t = logic [DATA_WIDTH-1:0],
    parameter int  DEPTH  = 16,
    parameter int  SALT   = 0
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    output word_t                    data
);

    // Number of pixel lanes in one word
    localparam int LANES = $bits(word_t) / DATA_WIDTH;

    ////////////////////
    // Content pattern
    ////////////////////

    // Lane e of word a holds a*LANES + e + SALT, wrapped to one byte
    function automatic word_t pattern_word(input int a);
        word_t w;
        w = '0;
        for (int e = 0; e < LANES; e++) begin
            w[e*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'((a * LANES + e + SALT) % 256);
        end
        return w;
    endfunction

    // Constant table, fixed at elaboration
    word_t rom [DEPTH];

    for (genvar a = 0; a < DEPTH; a++) begin : g_rom
        assign rom[a] = pattern_word(a);
    end

    ////////////////////
    // Read port
    ////////////////////

    // Registered read, data valid one cycle after addr
    always_ff @(posedge clk) begin
        data <= rom[addr];
    end

    // Loader counters must never step past the table
    addr_in_range: assert property (
        @(posedge clk) !$isunknown(addr) |-> (int'(addr) < DEPTH)
    ) else $error("source_rom: address %0d out of range", addr);

endmodule

`default_nettype wire

//--- design/fm_init_loader.sv
`default_nettype none

module fm_init_loader import cnn_dt_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        init,
    output fm_word_t                    init_fm_data,
    output logic [WRITE_ADDR_WIDTH-1:0] write_fm_data_addr,
    output logic                        fm_write,
    output logic                        init_fm_data_done
);

    // Previous init level for edge detect
    logic init_q;
    // Rising edge of init
    logic init_rise;
    // Rise accepted only when idle
    logic load_start;
    // High while ROM reads are issued
    logic run;
    logic [FM_ADDR_WIDTH-1:0] rd_addr;

    assign init_rise  = init && !init_q;
    // Busy covers the read phase and the trailing write
    assign load_start = init_rise && !run && !fm_write;

    ////////////////////
    // Source ROM
    ////////////////////

    source_rom #(
        .word_t (fm_word_t),
        .DEPTH  (FM_DEPTH),
        .SALT   (FM_SALT)
    ) u_fm_rom (
        .clk  (clk),
        .addr (rd_addr),
        .data (init_fm_data)
    );

    ////////////////////
    // Transfer control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            init_q            <= 1'b0;
            run               <= 1'b0;
            rd_addr           <= '0;
            fm_write          <= 1'b0;
            init_fm_data_done <= 1'b0;
        end else begin
            init_q   <= init;
            // Strobe lines up with ROM output
            fm_write <= run;
            if (load_start) begin
                run               <= 1'b1;
                rd_addr           <= '0;
                // New load drops the old done
                init_fm_data_done <= 1'b0;
            end else if (run) begin
                rd_addr <= rd_addr + 1'b1;
                // Last read issued
                if (rd_addr == FM_ADDR_WIDTH'(FM_DEPTH - 1)) begin
                    run <= 1'b0;
                end
            end
            // Done follows the final write
            if (fm_write && write_fm_data_addr == WRITE_ADDR_WIDTH'(FM_DEPTH - 1)) begin
                init_fm_data_done <= 1'b1;
            end
        end
    end

    // Write address trails read address by the ROM latency
    always_ff @(posedge clk) begin
        write_fm_data_addr <= WRITE_ADDR_WIDTH'(rd_addr);
    end

    ////////////////////
    // Checks
    ////////////////////

    write_done_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(fm_write && init_fm_data_done)
    ) else $error("fm_init_loader: write strobe while done is high");

    write_addr_in_range: assert property (
        @(posedge clk) disable iff (rst) fm_write |-> (write_fm_data_addr < FM_DEPTH)
    ) else $error("fm_init_loader: write address %0d out of range", write_fm_data_addr);

endmodule

`default_nettype wire

//--- design/weight_loader.sv
`default_nettype none

module weight_loader import cnn_dt_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             update_weight_ram,
    input  logic [WEIGHT_ADDR_BUS_WIDTH-1:0] update_weight_ram_addr,
    output logic [WEIGHT_BUS_WIDTH-1:0]      weight_data,
    output logic [WEIGHT_ADDR_BUS_WIDTH-1:0] write_weight_data_addr,
    output logic                             weight_write,
    output logic                             weight_data_done
);

    logic update_q;
    logic load_start;
    logic run;
    // Marks the last write of the burst
    logic last_q;
    logic [BURST_CNT_WIDTH-1:0] burst_cnt;
    // Bases sampled on the detect cycle
    logic [WEIGHT_ADDR_BUS_WIDTH-1:0] base_q;

    // Per-kernel read address and ROM output
    logic [WEIGHT_WRITE_ADDR_WIDTH-1:0] rd_addr [PARA_KERNEL];
    weight_word_t rom_data [PARA_KERNEL];

    // Rise of the request, ignored while busy
    assign load_start = update_weight_ram && !update_q && !run && !weight_write;

    ////////////////////
    // Kernel ROMs
    ////////////////////

    // Base plus offset, wrapped to the kernel store
    always_comb begin
        for (int k = 0; k < PARA_KERNEL; k++) begin
            rd_addr[k] = WEIGHT_WRITE_ADDR_WIDTH'(
                (int'(base_q[k*WEIGHT_WRITE_ADDR_WIDTH +: WEIGHT_WRITE_ADDR_WIDTH])
                 + int'(burst_cnt)) % WEIGHT_DEPTH);
        end
    end

    for (genvar k = 0; k < PARA_KERNEL; k++) begin : g_kernel
        source_rom #(
            .word_t (weight_word_t),
            .DEPTH  (WEIGHT_DEPTH),
            .SALT   (WEIGHT_SALT_STEP * (k + 1))
        ) u_weight_rom (
            .clk  (clk),
            .addr (rd_addr[k]),
            .data (rom_data[k])
        );
    end

    // Pack kernel words, kernel 0 lowest
    always_comb begin
        for (int k = 0; k < PARA_KERNEL; k++) begin
            weight_data[k*WEIGHT_WORD_WIDTH +: WEIGHT_WORD_WIDTH] = rom_data[k];
        end
    end

    ////////////////////
    // Burst control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            update_q         <= 1'b0;
            run              <= 1'b0;
            last_q           <= 1'b0;
            burst_cnt        <= '0;
            weight_write     <= 1'b0;
            weight_data_done <= 1'b0;
        end else begin
            update_q     <= update_weight_ram;
            weight_write <= run;
            last_q       <= run && (burst_cnt == BURST_CNT_WIDTH'(WEIGHT_BURST - 1));
            if (load_start) begin
                run              <= 1'b1;
                burst_cnt        <= '0;
                weight_data_done <= 1'b0;
            end else if (run) begin
                burst_cnt <= burst_cnt + 1'b1;
                if (burst_cnt == BURST_CNT_WIDTH'(WEIGHT_BURST - 1)) begin
                    run <= 1'b0;
                end
            end
            // Done one cycle after the final write
            if (last_q) begin
                weight_data_done <= 1'b1;
            end
        end
    end

    // Base latch and delayed write addresses
    always_ff @(posedge clk) begin
        if (load_start) begin
            base_q <= update_weight_ram_addr;
        end
        for (int k = 0; k < PARA_KERNEL; k++) begin
            write_weight_data_addr[k*WEIGHT_WRITE_ADDR_WIDTH +: WEIGHT_WRITE_ADDR_WIDTH]
                <= rd_addr[k];
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    write_done_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(weight_write && weight_data_done)
    ) else $error("weight_loader: write strobe while done is high");

endmodule

`default_nettype wire

//--- design/data_transmission.sv
`default_nettype none

module data_transmission import cnn_dt_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             init,
    output logic                             start,
    input  logic                             update_weight_ram,
    input  logic [WEIGHT_ADDR_BUS_WIDTH-1:0] update_weight_ram_addr,
    output fm_word_t                         init_fm_data,
    output logic [WRITE_ADDR_WIDTH-1:0]      write_fm_data_addr,
    output logic                             fm_write,
    output logic                             init_fm_data_done,
    output logic [WEIGHT_BUS_WIDTH-1:0]      weight_data,
    output logic [WEIGHT_ADDR_BUS_WIDTH-1:0] write_weight_data_addr,
    output logic                             weight_write,
    output logic                             weight_data_done
);

    // Both buffers filled
    logic both_done;
    // Previous cycle of both_done
    logic both_done_q;

    assign both_done = init_fm_data_done && weight_data_done;

    ////////////////////
    // Feature-map path
    ////////////////////

    fm_init_loader u_fm_init_loader (
        .clk                (clk),
        .rst                (rst),
        .init               (init),
        .init_fm_data       (init_fm_data),
        .write_fm_data_addr (write_fm_data_addr),
        .fm_write           (fm_write),
        .init_fm_data_done  (init_fm_data_done)
    );

    ////////////////////
    // Weight path
    ////////////////////

    weight_loader u_weight_loader (
        .clk                    (clk),
        .rst                    (rst),
        .update_weight_ram      (update_weight_ram),
        .update_weight_ram_addr (update_weight_ram_addr),
        .weight_data            (weight_data),
        .write_weight_data_addr (write_weight_data_addr),
        .weight_write           (weight_write),
        .weight_data_done       (weight_data_done)
    );

    ////////////////////
    // Start pulse
    ////////////////////

    // One pulse per rise of the combined done level
    always_ff @(posedge clk) begin
        if (rst) begin
            both_done_q <= 1'b0;
            start       <= 1'b0;
        end else begin
            both_done_q <= both_done;
            start       <= both_done && !both_done_q;
        end
    end

    // Compute array sees a single-cycle kick
    start_single_cycle: assert property (
        @(posedge clk) disable iff (rst) start |=> !start
    ) else $error("data_transmission: start held for two cycles");

endmodule

`default_nettype wire

//--- verif/dt_tb.sv
`default_nettype none

module dt_tb import cnn_dt_pkg::*; ();

    logic                             clk;
    logic                             rst;
    logic                             init;
    logic                             start;
    logic                             update_weight_ram;
    logic [WEIGHT_ADDR_BUS_WIDTH-1:0] update_weight_ram_addr;
    fm_word_t                         init_fm_data;
    logic [WRITE_ADDR_WIDTH-1:0]      write_fm_data_addr;
    logic                             fm_write;
    logic                             init_fm_data_done;
    logic [WEIGHT_BUS_WIDTH-1:0]      weight_data;
    logic [WEIGHT_ADDR_BUS_WIDTH-1:0] write_weight_data_addr;
    logic                             weight_write;
    logic                             weight_data_done;

    // Bases of the current weight burst, as driven
    logic [WEIGHT_ADDR_BUS_WIDTH-1:0] wt_base = '0;
    int seed = 44509;
    int errors = 0;
    int timeouts = 0;
    // Running totals seen by the comparison process
    int fm_total = 0;
    int wt_total = 0;
    int start_total = 0;
    // Next expected index within the current transfer
    int fm_idx = 0;
    int wt_idx = 0;
    // Previous sampled levels
    logic fm_write_q = 1'b0;
    logic wt_write_q = 1'b0;
    logic fm_done_q = 1'b0;
    logic wt_done_q = 1'b0;
    logic both_q = 1'b0;
    logic both_qq = 1'b0;

    data_transmission DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Feature-map ROM, salt 0, lane e of word a is a*lanes + e
    function automatic fm_word_t fm_expect(input int a);
        fm_word_t w;
        int lanes;
        lanes = PARA_X * PARA_Y;
        w = '0;
        for (int e = 0; e < lanes; e++) begin
            w[e*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'((a * lanes + e) % 256);
        end
        return w;
    endfunction

    // Kernel k ROM, salt 17*(k+1)
    function automatic weight_word_t weight_expect(input int k, input int a);
        weight_word_t w;
        int lanes;
        lanes = KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;
        w = '0;
        for (int e = 0; e < lanes; e++) begin
            w[e*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'((a * lanes + e + 17 * (k + 1)) % 256);
        end
        return w;
    endfunction

    // Per-kernel fields of the packed buses, kernel 0 lowest
    function automatic int base_of(input int k);
        return int'(wt_base[k*WEIGHT_WRITE_ADDR_WIDTH +: WEIGHT_WRITE_ADDR_WIDTH]);
    endfunction

    function automatic int waddr_of(input int k);
        return int'(write_weight_data_addr[k*WEIGHT_WRITE_ADDR_WIDTH +: WEIGHT_WRITE_ADDR_WIDTH]);
    endfunction

    function automatic weight_word_t wdata_of(input int k);
        return weight_data[k*WEIGHT_WORD_WIDTH +: WEIGHT_WORD_WIDTH];
    endfunction

    ////////////////////
    // Reporting and waits
    ////////////////////

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("ERROR %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("FAILURE %0t: %s", $time, msg);
        errors++;
    endtask

    // sel 0 fm done, 1 weight done, 2 start count
    task automatic wait_until(input int sel, input int target, input string what);
        int n;
        int level;
        n = 0;
        level = -1;
        while (level != target && n < 200) begin
            // Start count moves on the falling edge, so read it on the rising one
            if (sel == 2) begin
                @(posedge clk);
            end else begin
                @(negedge clk);
            end
            case (sel)
                0: level = int'(init_fm_data_done);
                1: level = int'(weight_data_done);
                default: level = start_total;
            endcase
            n++;
        end
        if (level != target) begin
            $display("TIMEOUT %0t: gave up waiting for %s after %0d cycles", $time, what, n);
            timeouts++;
        end
    endtask

    // New random bases, then wait for the old done to drop and the new one to rise
    task automatic weight_update();
        @(posedge clk);
        wt_base = WEIGHT_ADDR_BUS_WIDTH'($random(seed));
        update_weight_ram_addr <= wt_base;
        update_weight_ram <= 1'b1;
        wait_until(1, 0, "weight_data_done to clear");
        wait_until(1, 1, "weight_data_done");
        @(posedge clk);
        update_weight_ram <= 1'b0;
    endtask

    ////////////////////
    // Comparison
    ////////////////////

    // Outputs move on the rising edge, sampled on the falling one
    always @(negedge clk) begin
        logic exp_start;
        int exp_a;
        if (!rst) begin
            // Start one cycle after both done levels first seen high
            exp_start = both_q && !both_qq;
            if (start !== exp_start) begin
                report_mismatch("start", start, exp_start);
            end
            if (start) begin
                start_total++;
            end
            both_qq = both_q;
            both_q = init_fm_data_done && weight_data_done;

            // Feature-map strobes
            if (fm_write) begin
                if (write_fm_data_addr !== WRITE_ADDR_WIDTH'(fm_idx)) begin
                    report_mismatch("write_fm_data_addr", write_fm_data_addr, fm_idx);
                end
                if (init_fm_data !== fm_expect(fm_idx)) begin
                    report_mismatch("init_fm_data", init_fm_data, fm_expect(fm_idx));
                end
                if (init_fm_data_done) begin
                    report_failure("fm_write and init_fm_data_done high together");
                end
                fm_idx++;
                fm_total++;
            end
            if (init_fm_data_done && !fm_done_q) begin
                if (fm_idx != FM_DEPTH || !fm_write_q) begin
                    report_failure("init_fm_data_done rose without a full load just before");
                end
                fm_idx = 0;
            end

            // Weight strobes, all kernels in lockstep
            if (weight_write) begin
                if (weight_data_done) begin
                    report_failure("weight_write and weight_data_done high together");
                end
                if (wt_idx >= WEIGHT_BURST) begin
                    report_failure("more weight writes than one burst");
                end
                for (int k = 0; k < PARA_KERNEL; k++) begin
                    exp_a = (base_of(k) + wt_idx) % WEIGHT_DEPTH;
                    if (waddr_of(k) != exp_a) begin
                        report_mismatch($sformatf("write_weight_data_addr[%0d]", k),
                                        waddr_of(k), exp_a);
                    end
                    if (wdata_of(k) !== weight_expect(k, exp_a)) begin
                        report_mismatch($sformatf("weight_data[%0d]", k),
                                        wdata_of(k), weight_expect(k, exp_a));
                    end
                end
                wt_idx++;
                wt_total++;
            end
            if (weight_data_done && !wt_done_q) begin
                if (wt_idx != WEIGHT_BURST || !wt_write_q) begin
                    report_failure("weight_data_done rose without a full burst just before");
                end
                wt_idx = 0;
            end

            fm_write_q = fm_write;
            wt_write_q = weight_write;
            fm_done_q = init_fm_data_done;
            wt_done_q = weight_data_done;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        rst = 1'b1;
        init = 1'b0;
        update_weight_ram = 1'b0;
        update_weight_ram_addr = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Quiet period, nothing requested yet
        repeat (10) @(posedge clk);
        if (fm_total != 0 || wt_total != 0 || start_total != 0) begin
            report_failure("write or start seen before any request");
        end
        @(negedge clk);
        if (init_fm_data_done || weight_data_done) begin
            report_failure("done level high before any request");
        end

        // First load, init held high for about 40 cycles
        @(posedge clk);
        init <= 1'b1;
        wait_until(0, 1, "init_fm_data_done");
        repeat (20) @(posedge clk);
        init <= 1'b0;
        if (fm_total != FM_DEPTH || start_total != 0) begin
            report_failure($sformatf("%0d fm writes and %0d starts after first load",
                                     fm_total, start_total));
        end

        // Weight bursts, each completion gives one start
        weight_update();
        wait_until(2, 1, "first start pulse");
        weight_update();
        wait_until(2, 2, "second start pulse");
        if (wt_total != 2 * WEIGHT_BURST) begin
            report_failure($sformatf("%0d weight writes after two bursts", wt_total));
        end

        // Reload, second rise of init lands inside the transfer
        @(posedge clk);
        init <= 1'b1;
        wait_until(0, 0, "init_fm_data_done to clear");
        @(posedge clk);
        init <= 1'b0;
        repeat (3) @(posedge clk);
        init <= 1'b1;
        wait_until(0, 1, "init_fm_data_done after reload");
        wait_until(2, 3, "third start pulse");
        @(posedge clk);
        init <= 1'b0;
        repeat (10) @(posedge clk);
        if (fm_total != 2 * FM_DEPTH || start_total != 3) begin
            report_failure($sformatf("%0d fm writes and %0d starts at the end",
                                     fm_total, start_total));
        end

        $display("Summary: %0d errors, %0d timeouts, %0d fm writes, %0d weight writes, %0d starts",
                 errors, timeouts, fm_total, wt_total, start_total);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/cnn_dt_pkg.sv
design/source_rom.sv
design/fm_init_loader.sv
design/weight_loader.sv
design/data_transmission.sv
verif/dt_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := dt_tb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
